/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP       = imgConvTb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTS FAILED" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* conv3Tap.sv */
`include "imgConv_defines.svh"

module conv3Tap
  import imgConvPkg::*;
(
  input  logic       i_CLK,
  input  logic       i_rst,
  input  kernelT     i_kernel,
  input  windowT     i_window,
  output resultBeatT o_result
);

  localparam int PROD_W = 2 * `IMG_PIX_W;
  // Room for three full products
  localparam int SUM_W  = PROD_W + 2;

  logic [PROD_W-1:0] prod0;
  logic [PROD_W-1:0] prod1;
  logic [PROD_W-1:0] prod2;
  logic              prodValid;
  logic [SUM_W-1:0]  sum;
  resultT            resData;
  logic              resValid;

  ////////////////////////////////////////////////////////////
  // Stage 1 products
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_window.valid) begin
      prod0 <= i_kernel.k0 * i_window.p0;
      prod1 <= i_kernel.k1 * i_window.p1;
      prod2 <= i_kernel.k2 * i_window.p2;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2 sum and scale
  ////////////////////////////////////////////////////////////

  always_comb begin
    sum = SUM_W'(prod0) + SUM_W'(prod1) + SUM_W'(prod2);
  end

  // Worst case 3*255*255 >> 5 still fits 13 bits
  always_ff @(posedge i_CLK) begin
    if (prodValid) begin
      resData <= resultT'(sum >> `IMG_SHIFT);
    end
  end

  // Valid follows the data two cycles behind the window
  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      prodValid <= 1'b0;
      resValid  <= 1'b0;
    end else begin
      prodValid <= i_window.valid;
      resValid  <= prodValid;
    end
  end

  assign o_result = '{valid: resValid, data: resData};

endmodule

/* imgCmdRegs.sv */
`include "imgConv_defines.svh"

module imgCmdRegs
  import imgConvPkg::*;
(
  input  logic                      i_CLK,
  input  logic                      i_rst,
  input  logic [`IMG_GPIO_IN_W-1:0] i_gpioData,
  input  cmdCodeT                   i_gpioCtrl,
  input  logic                      i_gpioValid,
  input  logic                      i_eop,
  output kernelT                    o_kernel,
  output imgLenT                    o_imgLen,
  output logic                      o_pixWrite,
  output pixelT                     o_pixData,
  output logic                      o_run,
  output logic                      o_readAdvance,
  output logic                      o_readClear
);

  // Edge detection state
  logic   validPrev;
  logic   eopPrev;
  logic   validEdge;
  logic   eopRise;

  // Register file
  kernelT kernelReg;
  imgLenT imgLenReg;
  pixelT  pixDataReg;
  logic   runReg;
  logic   loadReg;

  // Single cycle strobes
  logic   pixWriteReg;
  logic   readAdvReg;
  logic   readClrReg;

  ////////////////////////////////////////////////////////////
  // Valid and end of processing edges
  ////////////////////////////////////////////////////////////

  always_comb begin
    // New command only on a low to high valid transition
    validEdge = i_gpioValid & ~validPrev;
    // Release run on a fresh completion only
    // since eop stays high from the previous image
    eopRise   = i_eop & ~eopPrev;
  end

  ////////////////////////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      validPrev   <= 1'b0;
      eopPrev     <= 1'b0;
      kernelReg   <= '0;
      imgLenReg   <= '0;
      runReg      <= 1'b0;
      loadReg     <= 1'b0;
      pixWriteReg <= 1'b0;
      readAdvReg  <= 1'b0;
      readClrReg  <= 1'b0;
    end else begin
      validPrev   <= i_gpioValid;
      eopPrev     <= i_eop;
      // Strobes last one cycle
      pixWriteReg <= 1'b0;
      readAdvReg  <= 1'b0;
      readClrReg  <= 1'b0;

      if (runReg) begin
        // Processing owns the block, commands dropped
        if (eopRise) begin
          runReg <= 1'b0;
        end
      end else if (validEdge) begin
        case (i_gpioCtrl)
          kernelLoad: begin
            kernelReg <= kernelT'(i_gpioData);
          end
          sizeLoad: begin
            // Length locked once pixels start arriving
            if (!loadReg) begin
              imgLenReg <= i_gpioData[`IMG_LEN_W-1:0];
            end
          end
          pixelLoad: begin
            loadReg     <= 1'b1;
            pixWriteReg <= 1'b1;
          end
          dataRequest: begin
            readAdvReg <= 1'b1;
          end
          goRun: begin
            // Hand over to sequencer and restart readback
            runReg     <= 1'b1;
            loadReg    <= 1'b0;
            readClrReg <= 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Pixel payload travels with the write strobe
  always_ff @(posedge i_CLK) begin
    if (!runReg && validEdge && i_gpioCtrl == pixelLoad) begin
      pixDataReg <= i_gpioData[`IMG_PIX_W-1:0];
    end
  end

  assign o_kernel      = kernelReg;
  assign o_imgLen      = imgLenReg;
  assign o_pixWrite    = pixWriteReg;
  assign o_pixData     = pixDataReg;
  assign o_run         = runReg;
  assign o_readAdvance = readAdvReg;
  assign o_readClear   = readClrReg;

endmodule

/* imgConvChk.sv */
`include "imgConv_defines.svh"

module imgConvChk (
  input logic                       i_CLK,
  input logic                       i_rst,
  input logic                       i_run,
  input logic                       i_eop,
  input logic [`IMG_GPIO_OUT_W-1:0] i_gpioData
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertion count, read by the testbench
  int failCount = 0;

  ////////////////////////////////////////////////////////////
  // Run and end of processing protocol
  ////////////////////////////////////////////////////////////

  // Run released only after eop was seen high
  aRunRelease: assert property (@(posedge i_CLK) disable iff (i_rst)
    $fell(i_run) |-> $past(i_eop))
  else begin
    failCount = failCount + 1;
    $error("run fell without end of processing high in the cycle before");
  end

  // Completion only while processing
  aEopInRun: assert property (@(posedge i_CLK) disable iff (i_rst)
    $rose(i_eop) |-> i_run)
  else begin
    failCount = failCount + 1;
    $error("end of processing rose while run was low");
  end

  // Flag held until the next goRun
  aEopHold: assert property (@(posedge i_CLK) disable iff (i_rst)
    (i_eop && !i_run) |=> i_eop)
  else begin
    failCount = failCount + 1;
    $error("end of processing dropped before the next run");
  end

  ////////////////////////////////////////////////////////////
  // Readback word layout
  ////////////////////////////////////////////////////////////

  aPadZero: assert property (@(posedge i_CLK) disable iff (i_rst)
    i_gpioData[`IMG_GPIO_OUT_W-2:`IMG_RES_W] == '0)
  else begin
    failCount = failCount + 1;
    $error("readback padding bits are not zero");
  end

endmodule

/* imgConvPkg.sv */
`include "imgConv_defines.svh"

package imgConvPkg;

  // Basic vectors
  typedef logic [`IMG_PIX_W-1:0] pixelT;
  typedef logic [`IMG_LEN_W-1:0] imgLenT;
  typedef logic [`IMG_RES_W-1:0] resultT;

  // Kernel word as loaded from GPIO, k0 in the low byte
  typedef struct packed {
    pixelT k2;
    pixelT k1;
    pixelT k0;
  } kernelT;

  // GPIO command codes, 5 to 7 unused
  typedef enum logic [2:0] {
    kernelLoad  = 3'd0,
    sizeLoad    = 3'd1,
    pixelLoad   = 3'd2,
    dataRequest = 3'd3,
    goRun       = 3'd4
  } cmdCodeT;

  // Pixel sequencer FSM
  typedef enum logic [1:0] {
    seqIdle,
    seqLoad,
    seqRun,
    seqDone
  } seqStateT;

  // Three consecutive pixels, p0 is the oldest
  typedef struct packed {
    logic  valid;
    pixelT p2;
    pixelT p1;
    pixelT p0;
  } windowT;

  // One scaled result beat
  typedef struct packed {
    logic   valid;
    resultT data;
  } resultBeatT;

endpackage

/* imgConvTb.sv */
`include "imgConv_defines.svh"

module imgConvTb
  import imgConvPkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int FIRST_LEN = 16;
  localparam int MAX_LEN2  = 40;
  // Commands take four cycles, processing about L plus pipeline
  localparam int IMG1_CYC  = (2 + FIRST_LEN + 2 + (FIRST_LEN - 2)) * 4 + FIRST_LEN + 8;
  localparam int IMG2_CYC  = (2 + MAX_LEN2 + 1 + (MAX_LEN2 - 2)) * 4 + MAX_LEN2 + 8;
  localparam int TIMEOUT_CYCLES = 2 * (10 + IMG1_CYC + IMG2_CYC);

  logic                       i_CLK;
  logic                       rst;
  logic [`IMG_GPIO_IN_W-1:0]  gpioData;
  cmdCodeT                    gpioCtrl;
  logic                       gpioValid;
  logic [`IMG_GPIO_OUT_W-1:0] o_gpioData;

  logic [31:0] lfsrState = 32'ha4de_06ab;
  int          valueErrors = 0;
  int          cycleCount = 0;

  tbClkGen uClkGen (
    .o_CLK (i_CLK),
    .o_rst (rst)
  );

  imgConvTop UUT (
    .i_CLK       (i_CLK),
    .i_rst       (rst),
    .i_gpioData  (gpioData),
    .i_gpioCtrl  (gpioCtrl),
    .i_gpioValid (gpioValid),
    .o_gpioData  (o_gpioData)
  );

  // Protocol checker on the internal run and eop
  bind imgConvTop imgConvChk uChk (
    .i_CLK      (i_CLK),
    .i_rst      (i_rst),
    .i_run      (run),
    .i_eop      (eop),
    .i_gpioData (o_gpioData)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic drawBits(input int n, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      lfsrState = lfsrNext(lfsrState);
      val = {val[30:0], lfsrState[0]};
    end
  endtask

  // Valid high two cycles, then low two cycles
  task automatic sendCmd(input cmdCodeT code, input logic [`IMG_GPIO_IN_W-1:0] word);
    @(negedge i_CLK);
    gpioCtrl  = code;
    gpioData  = word;
    gpioValid = 1'b1;
    repeat (2) @(negedge i_CLK);
    gpioValid = 1'b0;
    @(negedge i_CLK);
  endtask

  // Load, run, optionally reload kernel mid run, then read back
  task automatic runImage(input int imgIdx, input int len, input bit reloadDuringRun);
    logic [31:0] word;
    int          pixQ[$];
    int          expQ[$];
    int          k0;
    int          k1;
    int          k2;
    int          got;
    drawBits(24, word);
    k0 = int'(word[7:0]);
    k1 = int'(word[15:8]);
    k2 = int'(word[23:16]);
    sendCmd(kernelLoad, word[23:0]);
    sendCmd(sizeLoad, 24'(len));
    for (int i = 0; i < len; i++) begin
      drawBits(8, word);
      pixQ.push_back(int'(word[7:0]));
      sendCmd(pixelLoad, {16'h0, word[7:0]});
    end
    // Reference model, unsigned three-tap sum scaled down
    for (int i = 0; i + 2 < len; i++) begin
      expQ.push_back((k0 * pixQ[i] + k1 * pixQ[i+1] + k2 * pixQ[i+2]) >> `IMG_SHIFT);
    end
    sendCmd(goRun, 24'h0);
    assert (o_gpioData[31] == 1'b0) else begin
      valueErrors++;
      $display("Fail at %0d ns: image %0d eop still set after goRun", $time, imgIdx);
    end
    // Must be dropped, results keep the first kernel
    if (reloadDuringRun) begin
      drawBits(24, word);
      sendCmd(kernelLoad, word[23:0]);
    end
    while (!o_gpioData[31]) begin
      @(negedge i_CLK);
    end
    for (int i = 0; i < expQ.size(); i++) begin
      got = int'(o_gpioData[`IMG_RES_W-1:0]);
      assert (got == expQ[i]) else begin
        valueErrors++;
        $display("Fail at %0d ns: image %0d index %0d read %0d, expected %0d",
                 $time, imgIdx, i, got, expQ[i]);
      end
      assert (o_gpioData[31]) else begin
        valueErrors++;
        $display("Fail at %0d ns: image %0d eop low during readback", $time, imgIdx);
      end
      sendCmd(dataRequest, 24'h0);
    end
    // Past the last result nothing was written
    assert (o_gpioData[`IMG_RES_W-1:0] == '0) else begin
      valueErrors++;
      $display("Fail at %0d ns: image %0d has more than %0d results",
               $time, imgIdx, expQ.size());
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] word;
    int          len2;
    int          assertFails;
    gpioData  = '0;
    gpioCtrl  = kernelLoad;
    gpioValid = 1'b0;
    @(negedge rst);
    @(negedge i_CLK);
    assert (o_gpioData == '0) else begin
      valueErrors++;
      $display("Fail at %0d ns: readback word %h after reset", $time, o_gpioData);
    end
    runImage(1, FIRST_LEN, 1'b1);
    // Second length 3 to 40, never the first one
    drawBits(6, word);
    len2 = 3 + int'(word[5:0]) % (MAX_LEN2 - 2);
    if (len2 == FIRST_LEN) begin
      len2 = FIRST_LEN + 1;
    end
    runImage(2, len2, 1'b0);
    @(negedge i_CLK);
    assertFails = UUT.uChk.failCount;
    $display("Error counts: %0d value errors, %0d assertion failures",
             valueErrors, assertFails);
    if (valueErrors + assertFails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Run limit
  always @(posedge i_CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not complete within %0d clock cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

endmodule

/* imgConvTop.sv */
`include "imgConv_defines.svh"

module imgConvTop
  import imgConvPkg::*;
(
  input  logic                       i_CLK,
  input  logic                       i_rst,
  input  logic [`IMG_GPIO_IN_W-1:0]  i_gpioData,
  input  cmdCodeT                    i_gpioCtrl,
  input  logic                       i_gpioValid,
  output logic [`IMG_GPIO_OUT_W-1:0] o_gpioData
);

  // Command side
  kernelT     kernel;
  imgLenT     imgLen;
  logic       pixWrite;
  pixelT      pixData;
  logic       run;
  logic       readAdvance;
  logic       readClear;

  // Processing side
  logic       eop;
  windowT     window;
  resultBeatT resultBeat;

  // GPIO decode and register file
  imgCmdRegs uCmdRegs (
    .i_CLK         (i_CLK),
    .i_rst         (i_rst),
    .i_gpioData    (i_gpioData),
    .i_gpioCtrl    (i_gpioCtrl),
    .i_gpioValid   (i_gpioValid),
    .i_eop         (eop),
    .o_kernel      (kernel),
    .o_imgLen      (imgLen),
    .o_pixWrite    (pixWrite),
    .o_pixData     (pixData),
    .o_run         (run),
    .o_readAdvance (readAdvance),
    .o_readClear   (readClear)
  );

  // Line memory and window streaming
  pixelSequencer uPixelSeq (
    .i_CLK      (i_CLK),
    .i_rst      (i_rst),
    .i_imgLen   (imgLen),
    .i_pixWrite (pixWrite),
    .i_pixData  (pixData),
    .i_run      (run),
    .o_window   (window),
    .o_eop      (eop)
  );

  conv3Tap uConv (
    .i_CLK    (i_CLK),
    .i_rst    (i_rst),
    .i_kernel (kernel),
    .i_window (window),
    .o_result (resultBeat)
  );

  // Result store and readback
  resultBuffer uResultBuf (
    .i_CLK         (i_CLK),
    .i_rst         (i_rst),
    .i_result      (resultBeat),
    .i_eop         (eop),
    .i_readAdvance (readAdvance),
    .i_readClear   (readClear),
    .o_gpioData    (o_gpioData)
  );

endmodule

/* imgConv_defines.svh */
`ifndef IMG_CONV_DEFINES_SVH
`define IMG_CONV_DEFINES_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Pixel and kernel coefficient width
`define IMG_PIX_W 8
// Pixel count and line memory address width
`define IMG_LEN_W 10
// Largest image the line memory can hold
`define IMG_MAX_LEN 1023
// Scaled convolution result
`define IMG_RES_W 13
// Right shift on the raw three-tap sum
`define IMG_SHIFT 5

// GPIO port widths
`define IMG_GPIO_IN_W 24
`define IMG_GPIO_OUT_W 32

`endif

/* pixelSequencer.sv */
`include "imgConv_defines.svh"

module pixelSequencer
  import imgConvPkg::*;
(
  input  logic   i_CLK,
  input  logic   i_rst,
  input  imgLenT i_imgLen,
  input  logic   i_pixWrite,
  input  pixelT  i_pixData,
  input  logic   i_run,
  output windowT o_window,
  output logic   o_eop
);

  // Cycles from last window to last result written
  localparam int PIPE_LAT = 2;

  pixelT      lineMem [0:`IMG_MAX_LEN];
  seqStateT   state;
  imgLenT     wrAddr;
  imgLenT     rdAddr;
  logic       runPrev;
  logic       runStart;
  logic       fetch;
  logic       memWrite;
  logic [1:0] drainCnt;
  logic       eopReg;
  pixelT      rdPix;
  // Two older taps of the window
  pixelT      tap0;
  pixelT      tap1;

  always_comb begin
    runStart = i_run & ~runPrev;
    // One pixel per cycle from the run edge until the image is consumed
    fetch    = (runStart || state == seqRun) && (rdAddr < i_imgLen);
    // Line memory frozen while streaming
    memWrite = i_pixWrite && (state != seqRun);
    rdPix    = lineMem[rdAddr];
  end

  ////////////////////////////////////////////////////////////
  // Line memory and window taps
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (memWrite) begin
      lineMem[wrAddr] <= i_pixData;
    end
  end

  always_ff @(posedge i_CLK) begin
    if (fetch) begin
      tap1 <= rdPix;
      tap0 <= tap1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      state    <= seqIdle;
      wrAddr   <= '0;
      rdAddr   <= '0;
      runPrev  <= 1'b0;
      drainCnt <= '0;
      eopReg   <= 1'b0;
    end else begin
      runPrev <= i_run;
      if (memWrite) begin
        wrAddr <= wrAddr + 1'b1;
      end
      if (fetch) begin
        rdAddr <= rdAddr + 1'b1;
      end

      case (state)
        seqIdle, seqLoad, seqDone: begin
          if (runStart) begin
            // Next image load starts at address zero
            state    <= seqRun;
            wrAddr   <= '0;
            drainCnt <= '0;
            eopReg   <= 1'b0;
          end else if (memWrite) begin
            // eop kept until the next run
            state <= seqLoad;
          end
        end
        seqRun: begin
          if (!fetch) begin
            // Let the convolution pipeline empty
            if (drainCnt == 2'(PIPE_LAT - 1)) begin
              state  <= seqDone;
              rdAddr <= '0;
              eopReg <= 1'b1;
            end else begin
              drainCnt <= drainCnt + 1'b1;
            end
          end
        end
        default: begin
          state <= seqIdle;
        end
      endcase
    end
  end

  // Window valid from the third pixel on, L-2 windows per image
  always_comb begin
    o_window.p0    = tap0;
    o_window.p1    = tap1;
    o_window.p2    = rdPix;
    o_window.valid = fetch && (rdAddr >= imgLenT'(2));
  end

  assign o_eop = eopReg;

endmodule

/* resultBuffer.sv */
`include "imgConv_defines.svh"

module resultBuffer
  import imgConvPkg::*;
(
  input  logic                       i_CLK,
  input  logic                       i_rst,
  input  resultBeatT                 i_result,
  input  logic                       i_eop,
  input  logic                       i_readAdvance,
  input  logic                       i_readClear,
  output logic [`IMG_GPIO_OUT_W-1:0] o_gpioData
);

  localparam int PAD_W = `IMG_GPIO_OUT_W - 1 - `IMG_RES_W;

  // Holds one full image of results so nothing stalls
  resultT resMem [0:`IMG_MAX_LEN];
  imgLenT wrPtr;
  imgLenT rdPtr;
  logic   entryReady;
  resultT rdData;

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_result.valid && !i_readClear) begin
      resMem[wrPtr] <= i_result.data;
    end
  end

  // Clear wins over write and advance
  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else if (i_readClear) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (i_result.valid) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (i_readAdvance) begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Readback word
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Unwritten entries read as zero
    entryReady = rdPtr < wrPtr;
    rdData     = entryReady ? resMem[rdPtr] : '0;
  end

  // eop in bit 31, result in the low bits
  assign o_gpioData = {i_eop, {PAD_W{1'b0}}, rdData};

endmodule

/* tb.f */
+incdir+.
imgConvPkg.sv
imgCmdRegs.sv
pixelSequencer.sv
conv3Tap.sv
resultBuffer.sv
imgConvTop.sv
tbClkGen.sv
imgConvChk.sv
imgConvTb.sv

/* tbClkGen.sv */
module tbClkGen (
  output logic o_CLK,
  output logic o_rst
);

  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  localparam int HALF_PERIOD = 10;
  localparam int RST_CYCLES  = 8;

  initial begin
    o_CLK = 1'b0;
    forever #(HALF_PERIOD) o_CLK = ~o_CLK;
  end

  // Reset held for eight rising edges, released on a falling edge
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_CLK);
    @(negedge o_CLK);
    o_rst = 1'b0;
  end

endmodule
